// File: logic/scroll_adder.sv
// Front layer vertical scroll
`timescale 1ns/100ps

module scroll_adder (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          scroll_we,   // Load strobe from the data bus
    input  video_timing_pkg::coord_t      scroll_data,
    input  logic                          scroll_x8,   // Ninth scroll bit
    input  video_timing_pkg::coord_t      x_pos,       // Flipped line coordinate
    output video_timing_pkg::v_count_t    fv           // Scrolled line
);
    import video_timing_pkg::*;

    coord_t             scroll_q; // Latched scroll byte
    logic [COORD_W:0]   sum;      // Carry in the top bit

    //************************************************************
    // Scroll register
    //************************************************************
    // Loads on any edge with the strobe high, no acknowledge
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            scroll_q <= '0;
        end
        else if (scroll_we)
        begin
            scroll_q <= scroll_data;
        end
    end

    //************************************************************
    // Scrolled line
    //************************************************************
    // Same cycle as x_pos
    always_comb
    begin
        sum = {1'b0, scroll_q} + {1'b0, x_pos};
        fv  = {scroll_x8 ^ sum[COORD_W], sum[COORD_W-1:0]}; // Carry flips bit 8
    end

endmodule

// File: logic/sync_output_stage.sv
// Blank, sync and coordinate outputs
`timescale 1ns/100ps

module sync_output_stage #(
    parameter int H_ACTIVE     = 256, // Visible pixels
    parameter int H_SYNC_START = 288, // First sync pixel
    parameter int H_SYNC_LEN   = 32   // Sync width in pixels
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  video_timing_pkg::h_count_t    h_pos,
    input  video_timing_pkg::v_count_t    v_pos,
    input  video_timing_pkg::vstate_t     vstate,
    input  logic                          flip,   // Screen flip, inverts coordinates
    output logic                          hblank,
    output logic                          vblank,
    output logic                          hsync,
    output logic                          vsync,
    output logic                          csync,  // hsync XOR vsync
    output logic                          disp,   // Neither blank
    output video_timing_pkg::coord_t      x_pos,  // From line count
    output video_timing_pkg::coord_t      y_pos   // From pixel count
);
    import video_timing_pkg::*;

    localparam h_count_t HB_START = h_count_t'(H_ACTIVE);
    localparam h_count_t HS_START = h_count_t'(H_SYNC_START);
    localparam h_count_t HS_END   = h_count_t'(H_SYNC_START + H_SYNC_LEN);

    logic   hblank_d;
    logic   hsync_d;
    logic   vblank_d;
    logic   vsync_d;
    coord_t flip_mask; // All ones when flipped

    //************************************************************
    // Decode
    //************************************************************
    always_comb
    begin
        hblank_d  = (h_pos >= HB_START);                     // Right border onward
        hsync_d   = (h_pos >= HS_START) && (h_pos < HS_END); // Pulse window
        vblank_d  = (vstate != video_timing_pkg::V_ACTIVE);  // Porches and sync
        vsync_d   = (vstate == V_SYNC);
        flip_mask = {COORD_W{flip}};
    end

    //************************************************************
    // Output registers
    //************************************************************
    // One cycle behind the counters, no enable
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            hblank <= 1'b0;
            vblank <= 1'b0;
            hsync  <= 1'b0;
            vsync  <= 1'b0;
            csync  <= 1'b0;
            disp   <= 1'b0;
            x_pos  <= '0;
            y_pos  <= '0;
        end
        else
        begin
            hblank <= hblank_d;
            vblank <= vblank_d;
            hsync  <= hsync_d;
            vsync  <= vsync_d;
            csync  <= hsync_d ^ vsync_d;         // Serrated composite
            disp   <= ~(hblank_d | vblank_d);    // Visible area
            x_pos  <= v_pos[COORD_W-1:0] ^ flip_mask;
            y_pos  <= h_pos[COORD_W-1:0] ^ flip_mask;
        end
    end

endmodule

// File: logic/vblank_fsm.sv
// Vertical region state machine
`timescale 1ns/100ps

module vblank_fsm #(
    parameter int V_ACTIVE     = 224, // Visible lines
    parameter int V_SYNC_START = 232, // First sync line
    parameter int V_SYNC_LEN   = 8,   // Sync lines
    parameter int V_TOTAL      = 264  // Lines per frame
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          line_end, // v_pos steps on this edge
    input  video_timing_pkg::v_count_t    v_pos,    // Outgoing line
    output video_timing_pkg::vstate_t     vstate
);
    import video_timing_pkg::*;

    // Last line of each region, compared against the outgoing line
    localparam v_count_t ACT_LAST   = v_count_t'(V_ACTIVE - 1);
    localparam v_count_t FRONT_LAST = v_count_t'(V_SYNC_START - 1);
    localparam v_count_t SYNC_LAST  = v_count_t'(V_SYNC_START + V_SYNC_LEN - 1);
    localparam v_count_t FRAME_LAST = v_count_t'(V_TOTAL - 1);

    vstate_t state_q; // Region of current v_pos
    vstate_t state_d;

    //************************************************************
    // Next state
    //************************************************************
    // Moves only on line_end so the state turns with v_pos
    always_comb
    begin
        state_d = state_q;
        if (line_end)
        begin
            case (state_q)
                // Parameter V_ACTIVE hides the imported literal
                video_timing_pkg::V_ACTIVE:
                begin
                    if (v_pos == ACT_LAST)
                        state_d = V_FRONT;   // Blanking starts
                end
                V_FRONT:
                begin
                    if (v_pos == FRONT_LAST)
                        state_d = V_SYNC;    // Sync pulse starts
                end
                V_SYNC:
                begin
                    if (v_pos == SYNC_LAST)
                        state_d = V_BACK;    // Sync pulse ends
                end
                V_BACK:
                begin
                    if (v_pos == FRAME_LAST)
                        state_d = video_timing_pkg::V_ACTIVE; // Frame wraps
                end
                default:
                    state_d = video_timing_pkg::V_ACTIVE;
            endcase
        end
    end

    //************************************************************
    // State register
    //************************************************************
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            state_q <= video_timing_pkg::V_ACTIVE; // Line 0 is visible
        else
            state_q <= state_d;
    end

    assign vstate = state_q;

endmodule

// File: logic/video_counters.sv
// Raster position counters
`timescale 1ns/100ps

module video_counters #(
    parameter int H_TOTAL = 384, // Pixels per line, blanking included
    parameter int V_TOTAL = 264  // Lines per frame, blanking included
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          pix_cen,  // One pixel per high cycle
    output video_timing_pkg::h_count_t    h_pos,
    output video_timing_pkg::v_count_t    v_pos,
    output logic                          line_end  // Last pixel of line, enabled
);
    import video_timing_pkg::*;

    // Wrap points
    localparam h_count_t H_LAST = h_count_t'(H_TOTAL - 1);
    localparam v_count_t V_LAST = v_count_t'(V_TOTAL - 1);

    logic h_wrap; // h_pos sits on last pixel
    logic v_wrap; // v_pos sits on last line

    assign h_wrap = (h_pos == H_LAST);
    assign v_wrap = (v_pos == V_LAST);

    // Combinational, used by the vertical FSM on the same edge
    assign line_end = pix_cen & h_wrap;

    //************************************************************
    // Horizontal counter
    //************************************************************
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            h_pos <= '0;
        end
        else if (pix_cen)
        begin
            if (h_wrap)
                h_pos <= '0;         // New line
            else
                h_pos <= h_pos + 1'b1;
        end
    end

    //************************************************************
    // Vertical counter
    //************************************************************
    // Steps once per line, on the edge that wraps h_pos
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            v_pos <= '0;
        end
        else if (line_end)
        begin
            if (v_wrap)
                v_pos <= '0;         // New frame
            else
                v_pos <= v_pos + 1'b1;
        end
    end

endmodule

// File: logic/video_timing_pkg.sv
// Video timing shared types
package video_timing_pkg;

    //************************************************************
    // Widths
    //************************************************************
    localparam int COUNT_W = 9; // Position counters, up to 512 states
    localparam int COORD_W = 8; // Screen coordinate and scroll byte

    //************************************************************
    // Position and coordinate words
    //************************************************************
    // Pixel index within a line, 0 .. H_TOTAL-1
    typedef logic [COUNT_W-1:0] h_count_t;

    // Line index within a frame, 0 .. V_TOTAL-1
    typedef logic [COUNT_W-1:0] v_count_t;

    // Flipped screen coordinate, also the scroll register width
    typedef logic [COORD_W-1:0] coord_t;

    //************************************************************
    // Vertical regions
    //************************************************************
    // Order follows the raster: active lines, then front porch,
    // sync pulse and back porch before wrapping to line 0
    typedef enum logic [1:0] {
        V_ACTIVE = 2'd0, // Visible lines
        V_FRONT  = 2'd1, // Blank before sync
        V_SYNC   = 2'd2, // Sync pulse lines
        V_BACK   = 2'd3  // Blank after sync
    } vstate_t;

endpackage

// File: logic/video_timing_top.sv
// Video timing generator top
`timescale 1ns/100ps

module video_timing_top #(
    // Horizontal, in pixels
    parameter int H_ACTIVE     = 256,
    parameter int H_SYNC_START = 288,
    parameter int H_SYNC_LEN   = 32,
    parameter int H_TOTAL      = 384,
    // Vertical, in lines
    parameter int V_ACTIVE     = 224,
    parameter int V_SYNC_START = 232,
    parameter int V_SYNC_LEN   = 8,
    parameter int V_TOTAL      = 264
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          pix_cen,
    input  logic                          flip,
    input  logic                          scroll_we,
    input  video_timing_pkg::coord_t      scroll_data,
    input  logic                          scroll_x8,
    output video_timing_pkg::h_count_t    h_pos,
    output video_timing_pkg::v_count_t    v_pos,
    output logic                          hblank,
    output logic                          vblank,
    output logic                          hsync,
    output logic                          vsync,
    output logic                          csync,
    output logic                          disp,
    output video_timing_pkg::coord_t      x_pos,
    output video_timing_pkg::coord_t      y_pos,
    output video_timing_pkg::v_count_t    fv
);

    logic                       line_end; // Counter to FSM
    video_timing_pkg::vstate_t  vstate;   // FSM to output stage

    //************************************************************
    // Position counters
    //************************************************************
    video_counters #(
        .H_TOTAL (H_TOTAL),
        .V_TOTAL (V_TOTAL)
    ) i_video_counters (
        .clk      (clk),
        .rst_n    (rst_n),
        .pix_cen  (pix_cen),
        .h_pos    (h_pos),
        .v_pos    (v_pos),
        .line_end (line_end)
    );

    // Vertical regions
    vblank_fsm #(
        .V_ACTIVE     (V_ACTIVE),
        .V_SYNC_START (V_SYNC_START),
        .V_SYNC_LEN   (V_SYNC_LEN),
        .V_TOTAL      (V_TOTAL)
    ) i_vblank_fsm (
        .clk      (clk),
        .rst_n    (rst_n),
        .line_end (line_end),
        .v_pos    (v_pos),
        .vstate   (vstate)
    );

    //************************************************************
    // Outputs
    //************************************************************
    sync_output_stage #(
        .H_ACTIVE     (H_ACTIVE),
        .H_SYNC_START (H_SYNC_START),
        .H_SYNC_LEN   (H_SYNC_LEN)
    ) i_sync_output_stage (
        .clk    (clk),
        .rst_n  (rst_n),
        .h_pos  (h_pos),
        .v_pos  (v_pos),
        .vstate (vstate),
        .flip   (flip),
        .hblank (hblank),
        .vblank (vblank),
        .hsync  (hsync),
        .vsync  (vsync),
        .csync  (csync),
        .disp   (disp),
        .x_pos  (x_pos),
        .y_pos  (y_pos)
    );

    // Front layer scroll, fed by registered x_pos
    scroll_adder i_scroll_adder (
        .clk         (clk),
        .rst_n       (rst_n),
        .scroll_we   (scroll_we),
        .scroll_data (scroll_data),
        .scroll_x8   (scroll_x8),
        .x_pos       (x_pos),
        .fv          (fv)
    );

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the video timing testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary -j 0 -f verilog.f --top-module tb_video_timing > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/Vtb_video_timing > sim.log 2>&1
cat sim.log

# The log decides the result
grep -q "Test FAILED" sim.log && exit 1
grep -q "Test OK" sim.log || { echo "No result in log"; exit 1; }
exit 0

// File: verif/tb_video_ref.svh
// Video timing reference model
`ifndef TB_VIDEO_REF_SVH
`define TB_VIDEO_REF_SVH

// Pixel counter after one clock edge
function automatic logic [8:0] next_h(input logic [8:0] h, input logic cen);
    if (!cen)
        return h;                                 // Holds without enable
    return (h == H_LAST) ? 9'd0 : h + 9'd1;
endfunction

// Line counter after one clock edge, steps on the line wrap only
function automatic logic [8:0] next_v(input logic [8:0] h, input logic [8:0] v,
                                      input logic cen);
    if (!cen || (h != H_LAST))
        return v;
    return (v == V_LAST) ? 9'd0 : v + 9'd1;
endfunction

// Horizontal rules
function automatic logic ref_hblank(input logic [8:0] h);
    return h >= HB_FIRST;
endfunction

function automatic logic ref_hsync(input logic [8:0] h);
    return (h >= HS_FIRST) && (h < HS_END);
endfunction

// Vertical rules, blank covers front porch, sync and back porch
function automatic logic ref_vblank(input logic [8:0] v);
    return v >= VB_FIRST;
endfunction

function automatic logic ref_vsync(input logic [8:0] v);
    return (v >= VS_FIRST) && (v < VS_END);
endfunction

// Screen coordinate from a counter, inverted on flip
function automatic logic [7:0] ref_coord(input logic [8:0] p, input logic flp);
    return flp ? ~p[7:0] : p[7:0];
endfunction

// Scrolled line, a byte overflow toggles bit 8
function automatic logic [8:0] ref_fv(input logic [7:0] scr, input logic [7:0] x,
                                      input logic x8);
    int   total;
    logic carry;
    total = int'(scr) + int'(x);
    carry = (total > 255);                        // Sum left the byte range
    return {x8 ^ carry, 8'(total % 256)};
endfunction

`endif

// File: verif/tb_video_timing.sv
// Video timing generator testbench
`timescale 1ns/100ps

module tb_video_timing;

    //************************************************************
    // Small raster for a short run
    //************************************************************
    localparam int H_ACT = 32;
    localparam int H_SS  = 36;
    localparam int H_SL  = 4;
    localparam int H_TOT = 48;
    localparam int V_ACT = 20;
    localparam int V_SS  = 22;
    localparam int V_SL  = 2;
    localparam int V_TOT = 26;

    // Region limits as counter words
    localparam logic [8:0] HB_FIRST = 9'(H_ACT);
    localparam logic [8:0] HS_FIRST = 9'(H_SS);
    localparam logic [8:0] HS_END   = 9'(H_SS + H_SL);
    localparam logic [8:0] H_LAST   = 9'(H_TOT - 1);
    localparam logic [8:0] VB_FIRST = 9'(V_ACT);
    localparam logic [8:0] VS_FIRST = 9'(V_SS);
    localparam logic [8:0] VS_END   = 9'(V_SS + V_SL);
    localparam logic [8:0] V_LAST   = 9'(V_TOT - 1);

    localparam int FRAME_PIX      = H_TOT * V_TOT;     // 1248 enables per frame
    localparam int N_ENABLES      = 3 * FRAME_PIX;     // Three frames
    // Enables come at about 3 in 4 cycles, so twice the count leaves margin
    localparam int TIMEOUT_CYCLES = 2 * N_ENABLES + 512;

    logic       clk;
    logic       rst_n;
    logic       pix_cen;
    logic       flip;
    logic       scroll_we;
    logic [7:0] scroll_data;
    logic       scroll_x8;
    logic [8:0] h_pos;
    logic [8:0] v_pos;
    logic       hblank;
    logic       vblank;
    logic       hsync;
    logic       vsync;
    logic       csync;
    logic       disp;
    logic [7:0] x_pos;
    logic [7:0] y_pos;
    logic [8:0] fv;

    // Model state, holds what the DUT shows before the next edge
    logic [8:0] m_h;
    logic [8:0] m_v;
    logic       m_hblank;
    logic       m_vblank;
    logic       m_hsync;
    logic       m_vsync;
    logic       m_csync;
    logic       m_disp;
    logic [7:0] m_x;
    logic [7:0] m_y;
    logic [7:0] m_scroll;     // Last written scroll byte

    int          cycle_count = 0;
    int          en_count    = 0;    // Enables driven so far
    int          frame_idx   = 0;

    `include "tb_video_ref.svh"

    video_timing_top #(
        .H_ACTIVE     (H_ACT),
        .H_SYNC_START (H_SS),
        .H_SYNC_LEN   (H_SL),
        .H_TOTAL      (H_TOT),
        .V_ACTIVE     (V_ACT),
        .V_SYNC_START (V_SS),
        .V_SYNC_LEN   (V_SL),
        .V_TOTAL      (V_TOT)
    ) i_video_timing_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .pix_cen     (pix_cen),
        .flip        (flip),
        .scroll_we   (scroll_we),
        .scroll_data (scroll_data),
        .scroll_x8   (scroll_x8),
        .h_pos       (h_pos),
        .v_pos       (v_pos),
        .hblank      (hblank),
        .vblank      (vblank),
        .hsync       (hsync),
        .vsync       (vsync),
        .csync       (csync),
        .disp        (disp),
        .x_pos       (x_pos),
        .y_pos       (y_pos),
        .fv          (fv)
    );

    // 100 ns clock
    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Compares one value, stops at the first mismatch
    task automatic check_value(input string name, input logic [8:0] expected,
                               input logic [8:0] actual);
        if (actual !== expected)
        begin
            $display("FAIL %s expected 0x%0h actual 0x%0h at cycle %0d",
                     name, expected, actual, cycle_count);
            $display("Test FAILED");
            $fatal(1, "Output mismatch");
        end
    endtask

    // Reset values of every register
    task automatic reset_model();
        m_h      = '0;
        m_v      = '0;
        m_hblank = 1'b0;
        m_vblank = 1'b0;
        m_hsync  = 1'b0;
        m_vsync  = 1'b0;
        m_csync  = 1'b0;
        m_disp   = 1'b0;
        m_x      = '0;
        m_y      = '0;
        m_scroll = '0;
    endtask

    task automatic compare_outputs();
        check_value("h_pos", m_h, h_pos);
        check_value("v_pos", m_v, v_pos);
        check_value("hblank", 9'(m_hblank), 9'(hblank));
        check_value("vblank", 9'(m_vblank), 9'(vblank));
        check_value("hsync", 9'(m_hsync), 9'(hsync));
        check_value("vsync", 9'(m_vsync), 9'(vsync));
        check_value("csync", 9'(m_csync), 9'(csync));
        check_value("disp", 9'(m_disp), 9'(disp));
        check_value("x_pos", 9'(m_x), 9'(x_pos));
        check_value("y_pos", 9'(m_y), 9'(y_pos));
        check_value("fv", ref_fv(m_scroll, m_x, scroll_x8), fv); // Zero latency
    endtask

    // One clock edge of the model, inputs as driven on the last falling edge
    task automatic advance_model();
        logic [8:0] nxt_h;
        logic [8:0] nxt_v;
        nxt_h    = next_h(m_h, pix_cen);
        nxt_v    = next_v(m_h, m_v, pix_cen);
        m_hblank = ref_hblank(m_h);           // Outputs lag the counters
        m_hsync  = ref_hsync(m_h);
        m_vblank = ref_vblank(m_v);
        m_vsync  = ref_vsync(m_v);
        m_csync  = ref_hsync(m_h) ^ ref_vsync(m_v);
        m_disp   = !(ref_hblank(m_h) || ref_vblank(m_v));
        m_x      = ref_coord(m_v, flip);
        m_y      = ref_coord(m_h, flip);
        if (scroll_we)
            m_scroll = scroll_data;
        m_h = nxt_h;
        m_v = nxt_v;
    endtask

    //************************************************************
    // Compare process and timeout
    //************************************************************
    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Timeout after %0d cycles, only %0d pixel enables done",
                     cycle_count, en_count);
            $display("Test FAILED");
            $fatal(1, "Timeout");
        end
        if (!rst_n)
            reset_model();
        else
        begin
            compare_outputs();   // Values from before this edge
            advance_model();
        end
    end

    //************************************************************
    // Stimulus
    //************************************************************
    initial
    begin
        void'($urandom(80));
        rst_n       = 1'b0;
        pix_cen     = 1'b0;
        flip        = 1'b0;
        scroll_we   = 1'b0;
        scroll_data = '0;
        scroll_x8   = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        while (en_count < N_ENABLES)
        begin
            @(negedge clk);
            if ((en_count / FRAME_PIX) != frame_idx)
            begin
                frame_idx = en_count / FRAME_PIX;
                flip      = ~flip;                  // New frame
            end
            pix_cen     = ($urandom % 4) != 0;      // About 3 in 4
            scroll_data = 8'($urandom);             // Ignored without strobe
            scroll_we   = ($urandom % 64) == 0;
            if (scroll_we)
                scroll_x8 = 1'($urandom);
            if (pix_cen)
                en_count++;
        end
        @(negedge clk);
        pix_cen   = 1'b0;
        scroll_we = 1'b0;
        repeat (4) @(negedge clk);   // Last edges still compared
        $display("Test OK");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+verif
logic/video_timing_pkg.sv
logic/video_counters.sv
logic/vblank_fsm.sv
logic/sync_output_stage.sv
logic/scroll_adder.sv
logic/video_timing_top.sv
verif/tb_video_timing.sv
